//--- Makefile
# Verilator build and run for the MMU testbench

TOP       ?= mmu_tb
SEED      ?= 64
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

VFLAGS = --timing --assert -f compile.f --top-module $(TOP) -Gseed_init=$(SEED)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
src/tlb_pkg.sv
src/cp0_pkg.sv
src/tlb_entry_array.sv
src/tlb_search_port.sv
src/tlb_cp0_ctrl.sv
src/mmu_top.sv
verification/mmu_tb.sv

//--- src/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] cp0_word_t;

    typedef enum logic [1:0] {
        reg_index,
        reg_entryhi,
        reg_entrylo0,
        reg_entrylo1
    } cp0_reg_e;

    typedef enum logic [1:0] {
        op_tlbwi,
        op_tlbr,
        op_tlbp
    } tlb_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_done
    } ctrl_state_e;

    typedef struct packed {
        tlb_pkg::vpn2_t  vpn2;   // 31..13
        logic [4:0]      rsvd;
        tlb_pkg::asid_t  asid;   // 7..0
    } entryhi_t;

    typedef struct packed {
        logic [5:0]       rsvd;
        tlb_pkg::pfn_t    pfn;   // 25..6
        tlb_pkg::cattr_t  c;     // 5..3
        logic             d;
        logic             v;
        logic             g;
    } entrylo_t;

    // p set when the last probe missed
    typedef struct packed {
        logic        p;
        logic [30:0] num;
    } index_t;

endpackage

//--- src/mmu_top.sv
module mmu_top #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                    clk,
    input  logic                    reset,

    // instruction fetch lookup
    input  tlb_pkg::lookup_req_t    ifetch_req,
    output tlb_pkg::lookup_rsp_t    ifetch_rsp,
    output logic [idx_w-1:0]        ifetch_index,

    // data lookup
    input  tlb_pkg::lookup_req_t    data_req,
    output tlb_pkg::lookup_rsp_t    data_rsp,
    output logic [idx_w-1:0]        data_index,
    output logic                    data_busy,

    // coprocessor side
    input  logic                    cp0_wr,
    input  cp0_pkg::cp0_reg_e       cp0_sel,
    input  cp0_pkg::cp0_word_t      cp0_wdata,
    input  logic                    op_start,
    input  cp0_pkg::tlb_op_e        op,
    output logic                    op_done,
    output cp0_pkg::cp0_word_t      index_q,
    output cp0_pkg::cp0_word_t      entryhi_q,
    output cp0_pkg::cp0_word_t      entrylo0_q,
    output cp0_pkg::cp0_word_t      entrylo1_q
);

    tlb_pkg::tlb_entry_t [tlb_num-1:0] entries;
    tlb_pkg::tlb_entry_t               wr_entry;
    tlb_pkg::tlb_entry_t               rd_entry;
    tlb_pkg::lookup_req_t              s1_req;     // data_req or probe key
    logic                              wr_en;
    logic [idx_w-1:0]                  wr_index;
    logic [idx_w-1:0]                  rd_index;

    tlb_cp0_ctrl #(.tlb_num(tlb_num)) ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .cp0_wr      (cp0_wr),
        .cp0_sel     (cp0_sel),
        .cp0_wdata   (cp0_wdata),
        .op_start    (op_start),
        .op          (op),
        .op_done     (op_done),
        .data_req    (data_req),
        .data_busy   (data_busy),
        .s1_req      (s1_req),
        .probe_rsp   (data_rsp),
        .probe_index (data_index),
        .index_q     (index_q),
        .entryhi_q   (entryhi_q),
        .entrylo0_q  (entrylo0_q),
        .entrylo1_q  (entrylo1_q),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .rd_index    (rd_index),
        .rd_entry    (rd_entry)
    );

    tlb_entry_array #(.tlb_num(tlb_num)) array0 (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    // ifetch port
    tlb_search_port #(.tlb_num(tlb_num)) s0 (
        .req     (ifetch_req),
        .entries (entries),
        .rsp     (ifetch_rsp),
        .index   (ifetch_index)
    );

    // data port, also answers tlbp
    tlb_search_port #(.tlb_num(tlb_num)) s1 (
        .req     (s1_req),
        .entries (entries),
        .rsp     (data_rsp),
        .index   (data_index)
    );

endmodule

//--- src/tlb_cp0_ctrl.sv
module tlb_cp0_ctrl #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                    clk,
    input  logic                    reset,

    // register writes from the core
    input  logic                    cp0_wr,
    input  cp0_pkg::cp0_reg_e       cp0_sel,
    input  cp0_pkg::cp0_word_t      cp0_wdata,

    // tlb instructions
    input  logic                    op_start,
    input  cp0_pkg::tlb_op_e        op,
    output logic                    op_done,

    // data lookup, shared with tlbp
    input  tlb_pkg::lookup_req_t    data_req,
    output logic                    data_busy,
    output tlb_pkg::lookup_req_t    s1_req,
    input  tlb_pkg::lookup_rsp_t    probe_rsp,
    input  logic [idx_w-1:0]        probe_index,

    // register readout
    output cp0_pkg::cp0_word_t      index_q,
    output cp0_pkg::cp0_word_t      entryhi_q,
    output cp0_pkg::cp0_word_t      entrylo0_q,
    output cp0_pkg::cp0_word_t      entrylo1_q,

    // entry array access
    output logic                    wr_en,
    output logic [idx_w-1:0]        wr_index,
    output tlb_pkg::tlb_entry_t     wr_entry,
    output logic [idx_w-1:0]        rd_index,
    input  tlb_pkg::tlb_entry_t     rd_entry
);

    cp0_pkg::ctrl_state_e state;
    cp0_pkg::tlb_op_e     op_q;     // operation being executed

    cp0_pkg::index_t      index_r;
    cp0_pkg::entryhi_t    entryhi_r;
    cp0_pkg::entrylo_t    entrylo0_r;
    cp0_pkg::entrylo_t    entrylo1_r;

    cp0_pkg::entryhi_t    wdata_hi;
    cp0_pkg::entrylo_t    wdata_lo;
    logic                 exec_wi;
    logic                 exec_r;
    logic                 exec_p;

    function automatic tlb_pkg::tlb_page_t lo_to_page(input cp0_pkg::entrylo_t lo);
        tlb_pkg::tlb_page_t page;
        page.pfn = lo.pfn;
        page.c   = lo.c;
        page.d   = lo.d;
        page.v   = lo.v;
        return page;
    endfunction

    function automatic cp0_pkg::entrylo_t page_to_lo(input tlb_pkg::tlb_page_t page,
                                                     input logic g);
        cp0_pkg::entrylo_t lo;
        lo      = '0;
        lo.pfn  = page.pfn;
        lo.c    = page.c;
        lo.d    = page.d;
        lo.v    = page.v;
        lo.g    = g;
        return lo;
    endfunction

    assign wdata_hi = cp0_wdata;
    assign wdata_lo = cp0_wdata;

    assign exec_wi = (state == cp0_pkg::st_exec) && (op_q == cp0_pkg::op_tlbwi);
    assign exec_r  = (state == cp0_pkg::st_exec) && (op_q == cp0_pkg::op_tlbr);
    assign exec_p  = (state == cp0_pkg::st_exec) && (op_q == cp0_pkg::op_tlbp);

    // idle -> exec (one cycle) -> done (two cycles, op_done in the second)
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= cp0_pkg::st_idle;
            op_q    <= cp0_pkg::op_tlbwi;
            op_done <= 1'b0;
        end else begin
            op_done <= (state == cp0_pkg::st_done) && !op_done;
            case (state)
                cp0_pkg::st_idle: begin
                    if (op_start) begin
                        state <= cp0_pkg::st_exec;
                        op_q  <= op;
                    end
                end
                cp0_pkg::st_exec: state <= cp0_pkg::st_done;
                cp0_pkg::st_done: begin
                    if (op_done) state <= cp0_pkg::st_idle;
                end
                default: state <= cp0_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_r    <= '0;
            entryhi_r  <= '0;
            entrylo0_r <= '0;
            entrylo1_r <= '0;
        end else if (state == cp0_pkg::st_idle && cp0_wr) begin
            case (cp0_sel)
                cp0_pkg::reg_index: begin
                    index_r.p   <= cp0_wdata[31];
                    index_r.num <= 31'(cp0_wdata[idx_w-1:0]);
                end
                cp0_pkg::reg_entryhi:
                    entryhi_r <= '{vpn2: wdata_hi.vpn2, rsvd: '0, asid: wdata_hi.asid};
                cp0_pkg::reg_entrylo0: entrylo0_r <= page_to_lo(lo_to_page(wdata_lo), wdata_lo.g);
                cp0_pkg::reg_entrylo1: entrylo1_r <= page_to_lo(lo_to_page(wdata_lo), wdata_lo.g);
                default: ;
            endcase
        end else if (exec_r) begin
            entryhi_r  <= '{vpn2: rd_entry.vpn2, rsvd: '0, asid: rd_entry.asid};
            entrylo0_r <= page_to_lo(rd_entry.page0, rd_entry.g);   // g copied to both
            entrylo1_r <= page_to_lo(rd_entry.page1, rd_entry.g);
        end else if (exec_p) begin
            if (probe_rsp.found) begin
                index_r <= '{p: 1'b0, num: 31'(probe_index)};
            end else begin
                index_r.p <= 1'b1;  // index bits kept
            end
        end
    end

    assign wr_en              = exec_wi;
    assign wr_index           = index_r.num[idx_w-1:0];
    assign rd_index           = index_r.num[idx_w-1:0];
    assign wr_entry.vpn2      = entryhi_r.vpn2;
    assign wr_entry.asid      = entryhi_r.asid;
    assign wr_entry.g         = entrylo0_r.g & entrylo1_r.g;
    assign wr_entry.page0     = lo_to_page(entrylo0_r);
    assign wr_entry.page1     = lo_to_page(entrylo1_r);

    // probe key takes over the data port for the exec cycle
    assign data_busy = exec_p;
    always_comb begin
        if (exec_p) begin
            s1_req = '{vpn2: entryhi_r.vpn2, odd_page: 1'b0, asid: entryhi_r.asid};
        end else begin
            s1_req = data_req;
        end
    end

    assign index_q    = index_r;
    assign entryhi_q  = entryhi_r;
    assign entrylo0_q = entrylo0_r;
    assign entrylo1_q = entrylo1_r;

    op_start_idle: assert property (
        @(posedge clk) disable iff (reset) op_start |-> state == cp0_pkg::st_idle
    ) else $error("op_start while tlb operation in progress");

    cp0_wr_idle: assert property (
        @(posedge clk) disable iff (reset) cp0_wr |-> state == cp0_pkg::st_idle
    ) else $error("cp0 register write while tlb operation in progress");

endmodule

//--- src/tlb_entry_array.sv
module tlb_entry_array #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                                   clk,
    input  logic                                   reset,

    // write side, driven by tlbwi
    input  logic                                   wr_en,
    input  logic [idx_w-1:0]                       wr_index,
    input  tlb_pkg::tlb_entry_t                    wr_entry,

    // read side, used by tlbr
    input  logic [idx_w-1:0]                       rd_index,
    output tlb_pkg::tlb_entry_t                    rd_entry,

    // every entry at once for the search ports
    output tlb_pkg::tlb_entry_t [tlb_num-1:0]      entries
);

    // all-zero entries still match vpn2 0 / asid 0 until rewritten
    always_ff @(posedge clk) begin
        if (reset) begin
            entries <= '0;
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    assign rd_entry = entries[rd_index];    // combinational read

    // the sequencer must hand over a resolved, in-range index with each write
    wr_index_ok: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_index) && (int'(wr_index) < tlb_num)
    ) else $error("entry write with bad index %0d", wr_index);

endmodule

//--- src/tlb_pkg.sv
package tlb_pkg;

    typedef logic [18:0] vpn2_t;    // va[31:13]
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;

    // one half of a page pair
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;       // and of both written g bits
        tlb_page_t page0;   // even page
        tlb_page_t page1;   // odd page
    } tlb_entry_t;

    typedef struct packed {
        vpn2_t vpn2;
        logic  odd_page;    // va[12]
        asid_t asid;
    } lookup_req_t;

    // page is all zero on a miss
    typedef struct packed {
        logic      found;
        tlb_page_t page;
    } lookup_rsp_t;

endpackage

//--- src/tlb_search_port.sv
module tlb_search_port #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  tlb_pkg::lookup_req_t                   req,
    input  tlb_pkg::tlb_entry_t [tlb_num-1:0]      entries,
    output tlb_pkg::lookup_rsp_t                   rsp,
    output logic [idx_w-1:0]                       index
);

    logic [tlb_num-1:0]  match;
    tlb_pkg::tlb_entry_t hit;

    // vpn2 must agree; asid only matters for non-global entries
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            match[i] = (entries[i].vpn2 == req.vpn2) &&
                       ((entries[i].asid == req.asid) || entries[i].g);
        end
    end

    // lowest entry number wins, 0 on a miss
    always_comb begin
        index = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                index = idx_w'(i);
            end
        end
    end

    assign hit = entries[index];

    always_comb begin
        rsp.found = |match;
        if (!rsp.found) begin
            rsp.page = '0;
        end else if (req.odd_page) begin
            rsp.page = hit.page1;
        end else begin
            rsp.page = hit.page0;
        end
    end

    // software must never write two entries for the same key
    always_comb begin
        if (!$isunknown(match)) begin
            dup_entry: assert ($onehot0(match))
                else $error("multiple tlb entries match vpn2 %h asid %h",
                            req.vpn2, req.asid);
        end
    end

endmodule

//--- verification/mmu_tb.sv
module mmu_tb #(
    parameter int seed_init = 64
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int tlb_num = 16;
    localparam int idx_w = $clog2(tlb_num);
    localparam int max_cycles = 2000;

    logic clk;
    logic reset;
    tlb_pkg::lookup_req_t ifetch_req;
    tlb_pkg::lookup_rsp_t ifetch_rsp;
    logic [idx_w-1:0] ifetch_index;
    tlb_pkg::lookup_req_t data_req;
    tlb_pkg::lookup_rsp_t data_rsp;
    logic [idx_w-1:0] data_index;
    logic data_busy;
    logic cp0_wr;
    cp0_pkg::cp0_reg_e cp0_sel;
    cp0_pkg::cp0_word_t cp0_wdata;
    logic op_start;
    cp0_pkg::tlb_op_e op;
    logic op_done;
    cp0_pkg::cp0_word_t index_q;
    cp0_pkg::cp0_word_t entryhi_q;
    cp0_pkg::cp0_word_t entrylo0_q;
    cp0_pkg::cp0_word_t entrylo1_q;

    tlb_pkg::tlb_entry_t model [tlb_num];  // mirrors every tlbwi
    integer seed;
    int cycles;
    int errors;
    int errors_at_start;
    int pass_count;
    int fail_count;
    string cur_test;
    logic [4:0] busy_seen;      // per cycle of an op, cycle 0 has op_start
    logic [4:0] ifetch_seen;
    logic [4:0] data_seen;

    mmu_top #(.tlb_num(tlb_num)) dut0 (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            pass_count++;
            $display("%s: ok", cur_test);
        end else begin
            fail_count++;
            $display("%s: %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // EntryLo layout: pfn 25..6, c 5..3, d 2, v 1, g 0
    function automatic cp0_pkg::cp0_word_t lo_word(input tlb_pkg::tlb_page_t p, input logic g);
        return {6'b0, p.pfn, p.c, p.d, p.v, g};
    endfunction

    function automatic tlb_pkg::tlb_page_t rand_page();
        tlb_pkg::tlb_page_t p;
        p.pfn = 20'($random(seed));
        p.c   = 3'($random(seed));
        p.d   = 1'($random(seed));
        p.v   = 1'($random(seed));
        return p;
    endfunction

    // nonzero and not held by any entry
    function automatic tlb_pkg::vpn2_t fresh_vpn2();
        tlb_pkg::vpn2_t v;
        logic used;
        v = '0;
        used = 1'b1;
        while (used) begin
            v = 19'($random(seed));
            used = (v == '0);
            for (int i = 0; i < tlb_num; i++) begin
                if (model[i].vpn2 == v) used = 1'b1;
            end
        end
        return v;
    endfunction

    // lowest matching entry wins; vpn2 equal and asid equal or global
    function automatic tlb_pkg::lookup_rsp_t model_lookup(input tlb_pkg::lookup_req_t req,
                                                          output logic [idx_w-1:0] idx);
        tlb_pkg::lookup_rsp_t rsp;
        rsp = '0;
        idx = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (!rsp.found && model[i].vpn2 == req.vpn2 &&
                (model[i].asid == req.asid || model[i].g)) begin
                rsp.found = 1'b1;
                rsp.page  = req.odd_page ? model[i].page1 : model[i].page0;
                idx       = idx_w'(i);
            end
        end
        return rsp;
    endfunction

    task automatic write_reg(input cp0_pkg::cp0_reg_e sel, input cp0_pkg::cp0_word_t data);
        @(posedge clk);
        cp0_wr    <= 1'b1;
        cp0_sel   <= sel;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_wr    <= 1'b0;
    endtask

    task automatic record_cycle(input int k);
        busy_seen[k]   = data_busy;
        ifetch_seen[k] = ifetch_rsp.found;
        data_seen[k]   = data_rsp.found;
    endtask

    task automatic run_op(input cp0_pkg::tlb_op_e kind);
        int k;
        busy_seen   = '0;
        ifetch_seen = '0;
        data_seen   = '0;
        @(posedge clk);
        op_start <= 1'b1;
        op       <= kind;
        @(negedge clk);
        record_cycle(0);
        @(posedge clk);
        op_start <= 1'b0;
        k = 0;
        do begin
            k++;
            @(negedge clk);
            record_cycle(k);
        end while (!op_done && k < 4);
        if (!op_done) begin
            $display("%s: op_done did not arrive within 4 cycles of op_start", cur_test);
            errors++;
        end
        @(posedge clk);     // back in idle after this edge
    endtask

    task automatic write_entry(input int idx, input tlb_pkg::vpn2_t vpn2,
                               input tlb_pkg::asid_t asid, input logic g0, input logic g1,
                               input tlb_pkg::tlb_page_t p0, input tlb_pkg::tlb_page_t p1);
        write_reg(cp0_pkg::reg_index, 32'(idx));
        write_reg(cp0_pkg::reg_entryhi, {vpn2, 5'b0, asid});
        write_reg(cp0_pkg::reg_entrylo0, lo_word(p0, g0));
        write_reg(cp0_pkg::reg_entrylo1, lo_word(p1, g1));
        run_op(cp0_pkg::op_tlbwi);
        model[idx] = '{vpn2: vpn2, asid: asid, g: g0 & g1, page0: p0, page1: p1};
    endtask

    // same request on both ports, sampled mid-cycle
    task automatic check_lookup(input tlb_pkg::vpn2_t vpn2, input logic odd,
                                input tlb_pkg::asid_t asid);
        tlb_pkg::lookup_req_t req;
        tlb_pkg::lookup_rsp_t exp_rsp;
        logic [idx_w-1:0] exp_idx;
        req = '{vpn2: vpn2, odd_page: odd, asid: asid};
        exp_rsp = model_lookup(req, exp_idx);
        @(posedge clk);
        ifetch_req <= req;
        data_req   <= req;
        @(negedge clk);
        check_val("ifetch rsp", {6'b0, exp_rsp}, {6'b0, ifetch_rsp});
        check_val("ifetch index", 32'(exp_idx), 32'(ifetch_index));
        check_val("data rsp", {6'b0, exp_rsp}, {6'b0, data_rsp});
        check_val("data index", 32'(exp_idx), 32'(data_index));
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        check_val("index", 32'h0, index_q);
        check_val("entryhi", 32'h0, entryhi_q);
        check_val("entrylo0", 32'h0, entrylo0_q);
        check_val("entrylo1", 32'h0, entrylo1_q);
        check_val("op_done", 32'h0, 32'(op_done));
        check_val("data_busy", 32'h0, 32'(data_busy));
        check_lookup(19'h1_2345, 1'b0, 8'h00);
        finish_test();
    endtask

    task automatic test_write_translate();
        start_test("write_translate");
        for (int i = 0; i < 8; i++) begin
            write_entry(i, fresh_vpn2(), 8'($random(seed)), 1'b0, 1'b0,
                        rand_page(), rand_page());
        end
        for (int i = 0; i < 8; i++) begin
            check_lookup(model[i].vpn2, 1'b0, model[i].asid);
            check_lookup(model[i].vpn2, 1'b1, model[i].asid);
        end
        check_lookup(fresh_vpn2(), 1'b0, 8'($random(seed)));
        finish_test();
    endtask

    task automatic test_asid_global();
        start_test("asid_global");
        write_entry(8, fresh_vpn2(), 8'h11, 1'b0, 1'b0, rand_page(), rand_page());
        write_entry(9, fresh_vpn2(), 8'h33, 1'b1, 1'b1, rand_page(), rand_page());
        write_entry(10, fresh_vpn2(), 8'h55, 1'b1, 1'b0, rand_page(), rand_page());
        check_lookup(model[8].vpn2, 1'b0, 8'h11);
        check_lookup(model[8].vpn2, 1'b1, 8'h22);     // other asid
        check_lookup(model[9].vpn2, 1'b1, 8'h44);
        check_lookup(model[9].vpn2, 1'b0, 8'h00);
        check_lookup(model[10].vpn2, 1'b0, 8'h66);    // only one g bit set
        check_lookup(model[10].vpn2, 1'b1, 8'h55);
        finish_test();
    endtask

    task automatic test_tlbr();
        int picks [5] = '{0, 3, 7, 9, 10};
        tlb_pkg::tlb_entry_t m;
        start_test("tlbr_readback");
        foreach (picks[j]) begin
            m = model[picks[j]];
            write_reg(cp0_pkg::reg_index, 32'(picks[j]));
            run_op(cp0_pkg::op_tlbr);
            @(negedge clk);
            check_val("entryhi", {m.vpn2, 5'b0, m.asid}, entryhi_q);
            check_val("entrylo0", lo_word(m.page0, m.g), entrylo0_q);
            check_val("entrylo1", lo_word(m.page1, m.g), entrylo1_q);
            check_val("g in entrylo1", 32'(m.g), 32'(entrylo1_q[0]));
        end
        finish_test();
    endtask

    task automatic test_tlbp();
        start_test("tlbp_probe");
        write_reg(cp0_pkg::reg_index, 32'd3);
        write_reg(cp0_pkg::reg_entryhi, {model[5].vpn2, 5'b0, model[5].asid});
        run_op(cp0_pkg::op_tlbp);
        @(negedge clk);
        check_val("busy cycles", 32'b00010, 32'(busy_seen));
        check_val("index after hit", 32'h0000_0005, index_q);
        write_reg(cp0_pkg::reg_index, 32'd6);
        write_reg(cp0_pkg::reg_entryhi, {fresh_vpn2(), 5'b0, 8'h77});
        run_op(cp0_pkg::op_tlbp);
        @(negedge clk);
        check_val("busy cycles", 32'b00010, 32'(busy_seen));
        check_val("index after miss", 32'h8000_0006, index_q);
        finish_test();
    endtask

    task automatic test_overwrite();
        tlb_pkg::vpn2_t old_vpn2;
        tlb_pkg::vpn2_t new_vpn2;
        tlb_pkg::asid_t asid;
        start_test("overwrite");
        old_vpn2 = model[2].vpn2;
        asid     = model[2].asid;
        new_vpn2 = fresh_vpn2();
        @(posedge clk);
        ifetch_req <= '{vpn2: new_vpn2, odd_page: 1'b0, asid: asid};
        data_req   <= '{vpn2: old_vpn2, odd_page: 1'b1, asid: asid};
        write_entry(2, new_vpn2, asid, 1'b0, 1'b0, rand_page(), rand_page());
        // entry changes at the exec edge, seen from cycle 2 on
        check_val("ifetch found per cycle", 32'b01100, 32'(ifetch_seen));
        check_val("data found per cycle", 32'b00011, 32'(data_seen));
        check_lookup(old_vpn2, 1'b0, asid);
        check_lookup(new_vpn2, 1'b0, asid);
        check_lookup(new_vpn2, 1'b1, asid);
        finish_test();
    endtask

    initial begin
        seed       = seed_init;
        cycles     = 0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        reset      = 1'b1;
        // all-zero entries match key 0
        ifetch_req = '{vpn2: 19'h1_2345, odd_page: 1'b0, asid: 8'h00};
        data_req   = '{vpn2: 19'h1_2345, odd_page: 1'b0, asid: 8'h00};
        cp0_wr     = 1'b0;
        cp0_sel    = cp0_pkg::reg_index;
        cp0_wdata  = '0;
        op_start   = 1'b0;
        op         = cp0_pkg::op_tlbwi;
        foreach (model[i]) model[i] = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_state();
        test_write_translate();
        test_asid_global();
        test_tlbr();
        test_tlbp();
        test_overwrite();
        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
